// ==== hw/alu_unit.sv ====
/*
 * Single-cycle ALU
 * Add, subtract and xor, result reported with the issuing ID
 * one cycle after start
 */

module alu_unit
    import wb_config_pkg::*, wb_types_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  alu_op_t         op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  id_t             id,
    unit_wb_if.unit         wb
);

    logic [XLEN-1:0] result;

    always_comb begin
        case (op)
            ALU_SUB: result = a - b;
            ALU_XOR: result = a ^ b;
            default: result = a + b;
        endcase
    end

    // Done pulse follows start by one edge
    always_ff @(posedge clk) begin
        if (rst)
            wb.done <= 1'b0;
        else
            wb.done <= start;
    end

    // Result and ID held until the next start
    always_ff @(posedge clk) begin
        if (start) begin
            wb.rd <= result;
            wb.id <= id;
        end
    end

    // Always ready
    assign wb.busy = 1'b0;

endmodule

// ==== hw/id_tracking.sv ====
/*
 * Instruction ID tracking
 * Issue pointer, oldest pointer and in-flight count.
 * IDs are handed out and retired in the same circular order.
 */

module id_tracking
    import wb_config_pkg::*, wb_types_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    tracking_if.tracker   ti,
    input  logic          retired,
    output id_t           oldest_id,
    output logic          empty
);

    id_t                            issue_ptr;
    id_t                            oldest_ptr;
    logic [$clog2(MAX_INFLIGHT):0]  inflight_count;

    //////////////////////////////////////////////////
    // Pointers

    // Both pointers wrap at MAX_INFLIGHT through the id_t width
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_ptr <= '0;
            oldest_ptr <= '0;
        end else begin
            if (ti.issued)
                issue_ptr <= issue_ptr + 1'b1;
            if (retired)
                oldest_ptr <= oldest_ptr + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Occupancy

    always_ff @(posedge clk) begin
        if (rst) begin
            inflight_count <= '0;
        end else begin
            case ({ti.issued, retired})
                2'b10:   inflight_count <= inflight_count + 1'b1;
                2'b01:   inflight_count <= inflight_count - 1'b1;
                default: inflight_count <= inflight_count;
            endcase
        end
    end

    assign ti.id_available = (inflight_count < MAX_INFLIGHT);
    assign ti.issue_id = issue_ptr;
    assign oldest_id = oldest_ptr;
    assign empty = (inflight_count == '0);

endmodule

// ==== hw/mul_unit.sv ====
/*
 * Iterative multiplier
 * Shift-add, one multiplier bit per cycle over MUL_CYCLES iterations.
 * Low XLEN bits of the product reported with the issuing ID.
 */

module mul_unit
    import wb_config_pkg::*, wb_types_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  id_t             id,
    unit_wb_if.unit         wb
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_BUSY,
        S_DONE
    } mul_state_t;

    mul_state_t                     state;
    logic [$clog2(MUL_CYCLES)-1:0]  iter;
    logic [XLEN-1:0]                mcand;
    logic [XLEN-1:0]                mplier;
    logic [XLEN-1:0]                acc;
    id_t                            id_r;

    //////////////////////////////////////////////////
    // FSM

    // A new start is taken from idle or from the done cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            iter <= '0;
        end else begin
            case (state)
                S_BUSY: begin
                    iter <= iter + 1'b1;
                    if (iter == MUL_CYCLES - 1)
                        state <= S_DONE;
                end
                default: begin
                    iter <= '0;
                    state <= start ? S_BUSY : S_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Shift-add datapath

    always_ff @(posedge clk) begin
        if (start && state != S_BUSY) begin
            mcand <= a;
            mplier <= b;
            acc <= '0;
            id_r <= id;
        end else if (state == S_BUSY) begin
            // Add shifted multiplicand for each set multiplier bit
            if (mplier[0])
                acc <= acc + mcand;
            mcand <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // Done on the cycle after the last iteration
    assign wb.done = (state == S_DONE);
    assign wb.busy = (state == S_BUSY);
    assign wb.rd = acc;
    assign wb.id = id_r;

endmodule

// ==== hw/register_file.sv ====
/*
 * Register file
 * One commit write port, one asynchronous read port.
 * Register zero is never written.
 */

module register_file
    import wb_config_pkg::*, wb_types_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            we,
    input  reg_addr_t       wr_addr,
    input  logic            nzero,
    input  logic [XLEN-1:0] wr_data,
    input  reg_addr_t       rd_addr,
    output logic [XLEN-1:0] rd_data
);

    logic [XLEN-1:0] regs [REG_COUNT];

    // Writes to register zero dropped through nzero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++)
                regs[i] <= '0;
        end else if (we && nzero) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data = regs[rd_addr];

endmodule

// ==== hw/wb_config_pkg.sv ====
/*
 * Write-back core sizing
 * Data width, ID space, reporting units and multiplier length
 */

package wb_config_pkg;

    // Datapath width
    localparam int XLEN = 16;

    // Instruction IDs in flight, power of two so pointers wrap naturally
    localparam int MAX_INFLIGHT = 4;

    // Units reporting into write-back (ALU, MUL)
    localparam int NUM_WB_UNITS = 2;

    // One multiplier bit per iteration
    localparam int MUL_CYCLES = XLEN;

    // Architectural registers
    localparam int REG_COUNT = 16;

endpackage

// ==== hw/wb_interfaces.sv ====
/*
 * Write-back interfaces
 * unit_wb_if carries one unit's result report into write-back,
 * tracking_if links issue, ID tracking and the packet table
 */

interface unit_wb_if
    import wb_config_pkg::*, wb_types_pkg::*;
();

    // Single-cycle pulse, id and rd valid with it
    logic            done;
    id_t             id;
    logic [XLEN-1:0] rd;
    // Unit cannot take a new start
    logic            busy;

    modport unit (output done, id, rd, busy);
    modport wb (input done, id, rd, busy);

endinterface

interface tracking_if
    import wb_types_pkg::*;
();

    // Operation accepted this cycle
    logic             issued;
    // A free ID exists
    logic             id_available;
    // ID given to the next accepted operation
    id_t              issue_id;
    // Destination info of the operation being issued
    inflight_packet_t inflight_packet;

    modport tracker (input issued, output id_available, issue_id);
    modport wb (input issued, id_available, issue_id, inflight_packet);

endinterface

// ==== hw/wb_types_pkg.sv ====
/*
 * Write-back core types
 * IDs, register addresses, in-flight packet and issue encodings
 */

package wb_types_pkg;

    import wb_config_pkg::*;

    typedef logic [$clog2(MAX_INFLIGHT)-1:0] id_t;
    typedef logic [$clog2(REG_COUNT)-1:0] reg_addr_t;

    // Held per ID from issue until retirement
    typedef struct packed {
        reg_addr_t rd_addr;
        logic      rd_addr_nzero;
    } inflight_packet_t;

    // Execution unit select, also the unit's slot in the write-back array
    typedef enum logic {
        UNIT_ALU = 1'b0,
        UNIT_MUL = 1'b1
    } unit_sel_t;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_XOR = 2'd2
    } alu_op_t;

endpackage

// ==== hw/write_back.sv ====
/*
 * Write-back
 * Collects unit results out of order into a table indexed by ID,
 * keeps a done bit per ID and retires the oldest done ID each cycle.
 * The commit to the register file follows retirement by one cycle.
 */

module write_back
    import wb_config_pkg::*, wb_types_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    unit_wb_if.wb           unit_wb [NUM_WB_UNITS],
    tracking_if.wb          ti,
    input  id_t             oldest_id,
    input  logic            empty,
    output logic            retired,
    output logic            commit,
    output id_t             commit_id,
    output reg_addr_t       commit_rd,
    output logic            commit_rd_nzero,
    output logic [XLEN-1:0] commit_data
);

    // Unit report signals as arrays for dynamic indexing
    id_t                                unit_id [NUM_WB_UNITS];
    logic [NUM_WB_UNITS-1:0]            unit_done;
    logic [XLEN-1:0]                    unit_rd [NUM_WB_UNITS];

    logic [XLEN-1:0]                    rds_by_id [MAX_INFLIGHT];
    logic [$clog2(NUM_WB_UNITS)-1:0]    id_unit_sel [MAX_INFLIGHT];
    logic [MAX_INFLIGHT-1:0]            id_done_new;
    logic [MAX_INFLIGHT-1:0]            id_done_r;
    logic [MAX_INFLIGHT-1:0]            retire_onehot;

    inflight_packet_t                   packet_table [MAX_INFLIGHT];
    inflight_packet_t                   retired_packet;
    id_t                                retired_id_r;
    logic                               retired_r;

    for (genvar u = 0; u < NUM_WB_UNITS; u++) begin : g_unit_arrays
        assign unit_id[u] = unit_wb[u].id;
        assign unit_done[u] = unit_wb[u].done;
        assign unit_rd[u] = unit_wb[u].rd;
    end

    //////////////////////////////////////////////////
    // Result capture by ID

    // Which unit reports each ID this cycle, at most one
    always_comb begin
        for (int i = 0; i < MAX_INFLIGHT; i++) begin
            id_done_new[i] = 1'b0;
            id_unit_sel[i] = '0;
            for (int j = 0; j < NUM_WB_UNITS; j++) begin
                if (unit_done[j] && unit_id[j] == id_t'(i)) begin
                    id_unit_sel[i] = j[$clog2(NUM_WB_UNITS)-1:0];
                    id_done_new[i] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < MAX_INFLIGHT; i++) begin
            if (id_done_new[i])
                rds_by_id[i] <= unit_rd[id_unit_sel[i]];
        end
    end

    //////////////////////////////////////////////////
    // In-flight packets

    // Destination info written at the issue edge
    always_ff @(posedge clk) begin
        if (ti.issued)
            packet_table[ti.issue_id] <= ti.inflight_packet;
    end

    //////////////////////////////////////////////////
    // Done bits and retirement

    // Oldest ID leaves once its result is in the table
    assign retired = id_done_r[oldest_id] & ~empty;

    always_comb begin
        retire_onehot = '0;
        retire_onehot[oldest_id] = retired;
    end

    // Retired bit drops at the retire edge, new reports set theirs
    always_ff @(posedge clk) begin
        if (rst)
            id_done_r <= '0;
        else
            id_done_r <= (id_done_r & ~retire_onehot) | id_done_new;
    end

    always_ff @(posedge clk) begin
        if (rst)
            retired_r <= 1'b0;
        else
            retired_r <= retired;
    end

    // Packet and ID read out for the commit cycle
    always_ff @(posedge clk) begin
        retired_id_r <= oldest_id;
        retired_packet <= packet_table[oldest_id];
    end

    //////////////////////////////////////////////////
    // Commit

    assign commit = retired_r;
    assign commit_id = retired_id_r;
    assign commit_rd = retired_packet.rd_addr;
    assign commit_rd_nzero = retired_packet.rd_addr_nzero;
    assign commit_data = rds_by_id[retired_id_r];

endmodule

// ==== hw/writeback_core.sv ====
/*
 * Write-back core top level
 * Issue steering to ALU or multiplier, ID tracking,
 * in-order write-back and the register file
 */

module writeback_core
    import wb_config_pkg::*, wb_types_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            issue_valid,
    input  unit_sel_t       issue_unit,
    input  alu_op_t         issue_op,
    input  logic [XLEN-1:0] issue_a,
    input  logic [XLEN-1:0] issue_b,
    input  reg_addr_t       issue_rd,
    output logic            issue_ready,
    output logic            commit,
    output id_t             commit_id,
    output reg_addr_t       commit_rd,
    output logic [XLEN-1:0] commit_data,
    input  reg_addr_t       rf_read_addr,
    output logic [XLEN-1:0] rf_read_data
);

    unit_wb_if  unit_wb [NUM_WB_UNITS] ();
    tracking_if ti ();

    id_t  oldest_id;
    logic empty;
    logic retired;
    logic accept;
    logic commit_rd_nzero;

    //////////////////////////////////////////////////
    // Issue

    // Multiplier only takes a start while not iterating
    assign issue_ready = ti.id_available && (issue_unit == UNIT_ALU || !unit_wb[UNIT_MUL].busy);
    assign accept = issue_valid && issue_ready;

    assign ti.issued = accept;
    assign ti.inflight_packet.rd_addr = issue_rd;
    assign ti.inflight_packet.rd_addr_nzero = (issue_rd != '0);

    id_tracking id_tracking_i (
        .clk      (clk),
        .rst      (rst),
        .ti       (ti.tracker),
        .retired  (retired),
        .oldest_id(oldest_id),
        .empty    (empty)
    );

    //////////////////////////////////////////////////
    // Execution units

    alu_unit alu_unit_i (
        .clk  (clk),
        .rst  (rst),
        .start(accept && issue_unit == UNIT_ALU),
        .op   (issue_op),
        .a    (issue_a),
        .b    (issue_b),
        .id   (ti.issue_id),
        .wb   (unit_wb[UNIT_ALU].unit)
    );

    mul_unit mul_unit_i (
        .clk  (clk),
        .rst  (rst),
        .start(accept && issue_unit == UNIT_MUL),
        .a    (issue_a),
        .b    (issue_b),
        .id   (ti.issue_id),
        .wb   (unit_wb[UNIT_MUL].unit)
    );

    //////////////////////////////////////////////////
    // Write-back and commit

    write_back write_back_i (
        .clk            (clk),
        .rst            (rst),
        .unit_wb        (unit_wb),
        .ti             (ti.wb),
        .oldest_id      (oldest_id),
        .empty          (empty),
        .retired        (retired),
        .commit         (commit),
        .commit_id      (commit_id),
        .commit_rd      (commit_rd),
        .commit_rd_nzero(commit_rd_nzero),
        .commit_data    (commit_data)
    );

    register_file register_file_i (
        .clk    (clk),
        .rst    (rst),
        .we     (commit),
        .wr_addr(commit_rd),
        .nzero  (commit_rd_nzero),
        .wr_data(commit_data),
        .rd_addr(rf_read_addr),
        .rd_data(rf_read_data)
    );

endmodule

// ==== tests/writeback_core_tb.sv ====
/*
 * Write-back core testbench
 * Random ALU and multiply issue with back-pressure, expected commits
 * from a reference model, in-order commit and register file contents
 */

module writeback_core_tb
    import wb_config_pkg::*, wb_types_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    // Operations issued over all tests
    localparam int NUM_OPS = 48;
    localparam int TIMEOUT = NUM_OPS * (MUL_CYCLES + 8) * CLK_PERIOD;

    logic            clk;
    logic            rst;
    logic            issue_valid;
    unit_sel_t       issue_unit;
    alu_op_t         issue_op;
    logic [XLEN-1:0] issue_a;
    logic [XLEN-1:0] issue_b;
    reg_addr_t       issue_rd;
    logic            issue_ready;
    logic            commit;
    id_t             commit_id;
    reg_addr_t       commit_rd;
    logic [XLEN-1:0] commit_data;
    reg_addr_t       rf_read_addr;
    logic [XLEN-1:0] rf_read_data;

    // Expected commits in issue order
    id_t             exp_id_q [$];
    reg_addr_t       exp_rd_q [$];
    logic [XLEN-1:0] exp_data_q [$];
    string           exp_name_q [$];

    logic [XLEN-1:0] shadow_regs [REG_COUNT];
    id_t             next_id;
    integer          seed = 2067;
    int              errors = 0;
    int              checks = 0;
    int              issued_count = 0;
    int              commit_count = 0;
    string           pop_name;
    id_t             pop_id;
    reg_addr_t       pop_rd;
    logic [XLEN-1:0] pop_data;

    writeback_core writeback_core_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Reference model and helpers

    function automatic logic [XLEN-1:0] expected_result(input unit_sel_t unit, input alu_op_t op,
                                                        input logic [XLEN-1:0] a,
                                                        input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] product;
        product = a * b;
        if (unit == UNIT_MUL)
            return product[XLEN-1:0];
        case (op)
            ALU_SUB: return a - b;
            ALU_XOR: return a ^ b;
            default: return a + b;
        endcase
    endfunction

    task automatic log_mismatch(input string name, input string field,
                                input logic [XLEN-1:0] expected, input logic [XLEN-1:0] actual);
        errors++;
        $display("CHECK FAILED %s %s: expected %h actual %h", name, field, expected, actual);
    endtask

    // Called a step after a rising edge; holds the operation until accepted
    task automatic send_op(input string name, input unit_sel_t unit, input alu_op_t op,
                           input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                           input reg_addr_t rd, input bit expect_stall);
        issue_valid = 1'b1;
        issue_unit = unit;
        issue_op = op;
        issue_a = a;
        issue_b = b;
        issue_rd = rd;
        @(negedge clk);
        if (expect_stall) begin
            checks++;
            if (issue_ready)
                log_mismatch(name, "issue_ready", 0, 1);
        end
        while (!issue_ready)
            @(negedge clk);
        // Accepted at the coming edge
        exp_id_q.push_back(next_id);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(expected_result(unit, op, a, b));
        exp_name_q.push_back(name);
        next_id = next_id + 1'b1;
        issued_count++;
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
    endtask

    task automatic send_random(input string name, input unit_sel_t unit, input bit expect_stall);
        alu_op_t         op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        reg_addr_t       rd;
        op = alu_op_t'({$random(seed)} % 3);
        a = $random(seed);
        b = $random(seed);
        rd = reg_addr_t'({$random(seed)} % REG_COUNT);
        send_op(name, unit, op, a, b, rd, expect_stall);
    endtask

    task automatic wait_drain();
        while (exp_id_q.size() != 0)
            @(posedge clk);
        @(posedge clk);
        #1;
    endtask

    //////////////////////////////////////////////////
    // Commit comparison

    always @(negedge clk) begin
        if (!rst && commit) begin
            commit_count++;
            if (exp_id_q.size() == 0) begin
                errors++;
                $display("Commit of ID %0d arrived with no operation outstanding", commit_id);
            end else begin
                pop_name = exp_name_q.pop_front();
                pop_id = exp_id_q.pop_front();
                pop_rd = exp_rd_q.pop_front();
                pop_data = exp_data_q.pop_front();
                checks += 3;
                if (commit_id !== pop_id)
                    log_mismatch(pop_name, "commit_id", pop_id, commit_id);
                if (commit_rd !== pop_rd)
                    log_mismatch(pop_name, "commit_rd", pop_rd, commit_rd);
                if (commit_data !== pop_data)
                    log_mismatch(pop_name, "commit_data", pop_data, commit_data);
                // Register zero stays zero
                if (pop_rd != '0)
                    shadow_regs[pop_rd] = pop_data;
            end
        end
    end

    //////////////////////////////////////////////////
    // Test sequence

    initial begin
        rst = 1'b1;
        issue_valid = 1'b0;
        issue_unit = UNIT_ALU;
        issue_op = ALU_ADD;
        issue_a = '0;
        issue_b = '0;
        issue_rd = '0;
        rf_read_addr = '0;
        next_id = '0;
        for (int r = 0; r < REG_COUNT; r++)
            shadow_regs[r] = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // Idle after reset
        @(negedge clk);
        checks += 2;
        if (commit !== 1'b0)
            log_mismatch("reset_state", "commit", 0, commit);
        if (issue_ready !== 1'b1)
            log_mismatch("reset_state", "issue_ready", 1, issue_ready);
        @(posedge clk);
        #1;

        for (int i = 0; i < 12; i++)
            send_random("alu_stream", UNIT_ALU, 1'b0);
        wait_drain();

        for (int i = 0; i < 4; i++)
            send_random("mul_results", UNIT_MUL, 1'b0);
        wait_drain();

        // ALU results finish first but commit behind the multiply
        send_random("in_order", UNIT_MUL, 1'b0);
        for (int i = 0; i < 3; i++)
            send_random("in_order", UNIT_ALU, 1'b0);
        send_op("reg_zero", UNIT_ALU, ALU_ADD, 16'h1234, 16'h0001, '0, 1'b0);
        wait_drain();

        // Four in flight behind a running multiply
        send_random("backpressure_full", UNIT_MUL, 1'b0);
        for (int i = 0; i < 3; i++)
            send_random("backpressure_full", UNIT_ALU, 1'b0);
        send_random("backpressure_full", UNIT_ALU, 1'b1);
        wait_drain();

        // Second multiply while the first iterates
        send_random("backpressure_mul", UNIT_MUL, 1'b0);
        send_random("backpressure_mul", UNIT_MUL, 1'b1);
        wait_drain();

        for (int i = 0; i < 20; i++)
            send_random("random_mix", unit_sel_t'({$random(seed)} % 2), 1'b0);
        wait_drain();

        checks++;
        if (issued_count != commit_count) begin
            errors++;
            $display("Issued %0d operations but saw %0d commits", issued_count, commit_count);
        end

        // Register file against the shadow model
        for (int r = 0; r < REG_COUNT; r++) begin
            rf_read_addr = reg_addr_t'(r);
            @(negedge clk);
            checks++;
            if (rf_read_data !== shadow_regs[r])
                log_mismatch($sformatf("regfile_r%0d", r), "rf_read_data",
                             shadow_regs[r], rf_read_data);
            @(posedge clk);
            #1;
        end

        $display("Checks: %0d  Errors: %0d  Commits: %0d", checks, errors, commit_count);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // Watchdog

    initial begin
        #(TIMEOUT);
        $display("Timeout: run did not finish, %0d commits still outstanding", exp_id_q.size());
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== writeback_core.f ====
hw/wb_config_pkg.sv
hw/wb_types_pkg.sv
hw/wb_interfaces.sv
hw/id_tracking.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/write_back.sv
hw/register_file.sv
hw/writeback_core.sv
tests/writeback_core_tb.sv
